//--- Bender.yml
package:
  name: dma_datapath

sources:
  - files:
      - design/dmaPkg.sv
      - design/dmaHostPort.sv
      - design/dmaChannelRegs.sv
      - design/dmaControlRegs.sv
      - design/dmaDatapath.sv
  - target: simulation
    files:
      - sim/dmaClockGen.sv
      - sim/dmaDatapathTb.sv

//--- design/dmaChannelRegs.sv
// Per-channel 16-bit base and current registers; a CPU write beats a step on the same register
`timescale 1ns/1ns

module dmaChannelRegs (
  input  logic           dma_if,
  input  logic           rstN,
  input  dmaPkg::regOp   op,
  input  dmaPkg::chanIdx opChan,
  input  logic           hiByte,
  input  logic [7:0]     wrData,
  input  dmaPkg::chanIdx activeChan,
  input  logic           autoInit,
  input  logic           decrement,
  input  logic           stepEn,
  input  logic           xferStep,
  output logic [7:0]     addrByte,
  output logic [7:0]     countByte,
  output logic [15:0]    memAddr,
  output logic           tcPulse,
  output dmaPkg::chanIdx tcChan
);
  import dmaPkg::*;

  logic [15:0] baseAddr [NUM_CHANNELS];
  logic [15:0] baseCount [NUM_CHANNELS];
  logic [15:0] curAddr [NUM_CHANNELS];
  logic [15:0] curCount [NUM_CHANNELS];

  logic        stepNow;
  logic        countZero;
  logic [15:0] stepAddr;
  logic [15:0] stepCount;

  // Replace one byte of a 16-bit register
  function automatic logic [15:0] putByte(input logic [15:0] word, input logic hi,
                                          input logic [7:0] data);
    putByte = word;
    if (hi)
      putByte[15:8] = data;
    else
      putByte[7:0] = data;
  endfunction

  assign stepNow   = xferStep && stepEn;
  assign countZero = (curCount[activeChan] == 16'h0000);
  assign stepAddr  = decrement ? curAddr[activeChan] - 16'd1 : curAddr[activeChan] + 16'd1;
  // Count wraps to FFFF on terminal count
  assign stepCount = curCount[activeChan] - 16'd1;

  assign memAddr   = curAddr[activeChan];
  assign addrByte  = hiByte ? curAddr[opChan][15:8] : curAddr[opChan][7:0];
  assign countByte = hiByte ? curCount[opChan][15:8] : curCount[opChan][7:0];

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < NUM_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddr[i]   <= '0;
        curCount[i]  <= '0;
      end
      tcPulse <= 1'b0;
      tcChan  <= '0;
    end
    else if (op == opMasterClear)
    begin
      for (int i = 0; i < NUM_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddr[i]   <= '0;
        curCount[i]  <= '0;
      end
      tcPulse <= 1'b0;
      tcChan  <= '0;
    end
    else
    begin
      tcPulse <= stepNow && countZero;
      if (stepNow)
      begin
        tcChan <= activeChan;
        if (countZero && autoInit)
        begin
          // Autoinitialize reloads from base
          curAddr[activeChan]  <= baseAddr[activeChan];
          curCount[activeChan] <= baseCount[activeChan];
        end
        else
        begin
          curAddr[activeChan]  <= stepAddr;
          curCount[activeChan] <= stepCount;
        end
      end
      // Later assignments win over the step above
      if (op == opWrAddr)
      begin
        baseAddr[opChan] <= putByte(baseAddr[opChan], hiByte, wrData);
        curAddr[opChan]  <= putByte(curAddr[opChan], hiByte, wrData);
      end
      if (op == opWrCount)
      begin
        baseCount[opChan] <= putByte(baseCount[opChan], hiByte, wrData);
        curCount[opChan]  <= putByte(curCount[opChan], hiByte, wrData);
      end
    end
  end

  // Terminal count leaves the count wrapped or reloaded from base
  assert property (@(posedge dma_if) disable iff (!rstN)
    tcPulse && $past(op != opWrCount)
      |-> curCount[tcChan] == ($past(autoInit) ? baseCount[tcChan] : 16'hffff));

endmodule

//--- design/dmaControlRegs.sv
// Mode, command, request, mask and status registers; serviceMode and transferType are stored only
`timescale 1ns/1ns

module dmaControlRegs (
  input  logic                              dma_if,
  input  logic                              rstN,
  input  dmaPkg::regOp                      op,
  input  logic [7:0]                        wrData,
  input  logic                              tcPulse,
  input  dmaPkg::chanIdx                    tcChan,
  input  logic [dmaPkg::NUM_CHANNELS-1:0]   dreq,
  output dmaPkg::chanIdx                    activeChan,
  output logic                              autoInit,
  output logic                              decrement,
  output logic                              stepEn,
  output logic [7:0]                        status
);
  import dmaPkg::*;

  modeWord                 modes [NUM_CHANNELS];
  logic [7:0]              command;
  chanIdx                  reqChan;
  logic [NUM_CHANNELS-1:0] mask;
  ctlWord                  cw;
  logic                    tcNoAuto;
  logic [NUM_CHANNELS-1:0] tcSet;

  assign cw = wrData;

  assign activeChan = reqChan;
  assign autoInit   = modes[reqChan].autoInit;
  assign decrement  = modes[reqChan].decrement;

  assign tcNoAuto = tcPulse && !modes[tcChan].autoInit;
  assign tcSet    = tcPulse ? (NUM_CHANNELS'(1) << tcChan) : '0;

  // Mask bit lands a cycle after the TC step, so block that cycle too
  assign stepEn = !mask[reqChan] && !command[CMD_DISABLE_BIT]
                  && !(tcNoAuto && tcChan == reqChan);

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < NUM_CHANNELS; i++)
        modes[i] <= '0;
      command <= '0;
      reqChan <= '0;
      mask    <= '0;
    end
    else if (op == opMasterClear)
    begin
      for (int i = 0; i < NUM_CHANNELS; i++)
        modes[i] <= '0;
      command <= '0;
      reqChan <= '0;
      mask    <= '0;
    end
    else
    begin
      // Channel masks itself at TC without autoinitialize
      if (tcNoAuto)
        mask[tcChan] <= 1'b1;
      case (op)
        opWrMode:       modes[cw.mode.chan] <= cw.mode;
        opWrCommand:    command <= wrData;
        opWrRequest:    reqChan <= cw.bits.chan;
        opWrSingleMask: mask[cw.bits.chan] <= cw.bits.setBit;
        opClearMask:    mask <= '0;
        opWrAllMask:    mask <= wrData[NUM_CHANNELS-1:0];
        default:        ;
      endcase
    end
  end

  // Sticky TC flags cleared by a status read unless a new TC arrives
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      status <= 8'h00;
    else if (op == opMasterClear)
      status <= 8'h00;
    else
    begin
      status[7:4] <= dreq;
      if (op == opRdStatus)
        status[3:0] <= tcSet;
      else
        status[3:0] <= status[3:0] | tcSet;
    end
  end

  // Each TC flag rises only after a TC pulse for its channel
  for (genvar i = 0; i < NUM_CHANNELS; i++)
  begin : gTcFlag
    assert property (@(posedge dma_if) disable iff (!rstN)
      $rose(status[i]) |-> $past(tcPulse && tcChan == i));
  end

endmodule

//--- design/dmaDatapath.sv
// DMA register file and datapath top; no tri-state buses, no memory-to-memory path
`timescale 1ns/1ns

module dmaDatapath (
  input  logic                            dma_if,
  input  logic                            rstN,
  input  logic                            csN,
  input  logic                            iorN,
  input  logic                            iowN,
  input  logic [3:0]                      addr,
  input  logic [7:0]                      dataIn,
  input  logic                            progMode,
  input  logic                            xferStep,
  input  logic [dmaPkg::NUM_CHANNELS-1:0] dreq,
  output logic [7:0]                      dataOut,
  output logic [15:0]                     memAddr,
  output logic                            tc
);
  import dmaPkg::*;

  regOp       op;
  chanIdx     opChan;
  logic       hiByte;
  logic [7:0] wrData;
  logic [7:0] addrByte;
  logic [7:0] countByte;
  logic [7:0] status;
  chanIdx     activeChan;
  logic       autoInit;
  logic       decrement;
  logic       stepEn;
  logic       tcPulse;
  chanIdx     tcChan;

  assign tc = tcPulse;

  dmaHostPort hostPort (
    .dma_if    (dma_if),
    .rstN      (rstN),
    .csN       (csN),
    .iorN      (iorN),
    .iowN      (iowN),
    .addr      (addr),
    .dataIn    (dataIn),
    .progMode  (progMode),
    .addrByte  (addrByte),
    .countByte (countByte),
    .status    (status),
    .op        (op),
    .opChan    (opChan),
    .hiByte    (hiByte),
    .wrData    (wrData),
    .dataOut   (dataOut)
  );

  dmaChannelRegs channelRegs (
    .dma_if     (dma_if),
    .rstN       (rstN),
    .op         (op),
    .opChan     (opChan),
    .hiByte     (hiByte),
    .wrData     (wrData),
    .activeChan (activeChan),
    .autoInit   (autoInit),
    .decrement  (decrement),
    .stepEn     (stepEn),
    .xferStep   (xferStep),
    .addrByte   (addrByte),
    .countByte  (countByte),
    .memAddr    (memAddr),
    .tcPulse    (tcPulse),
    .tcChan     (tcChan)
  );

  dmaControlRegs controlRegs (
    .dma_if     (dma_if),
    .rstN       (rstN),
    .op         (op),
    .wrData     (wrData),
    .tcPulse    (tcPulse),
    .tcChan     (tcChan),
    .dreq       (dreq),
    .activeChan (activeChan),
    .autoInit   (autoInit),
    .decrement  (decrement),
    .stepEn     (stepEn),
    .status     (status)
  );

endmodule

//--- design/dmaHostPort.sv
// CPU register port: one access per strobed cycle in program mode, reads of 9..15 other than status give zero
`timescale 1ns/1ns

module dmaHostPort (
  input  logic           dma_if,
  input  logic           rstN,
  input  logic           csN,
  input  logic           iorN,
  input  logic           iowN,
  input  logic [3:0]     addr,
  input  logic [7:0]     dataIn,
  input  logic           progMode,
  input  logic [7:0]     addrByte,
  input  logic [7:0]     countByte,
  input  logic [7:0]     status,
  output dmaPkg::regOp   op,
  output dmaPkg::chanIdx opChan,
  output logic           hiByte,
  output logic [7:0]     wrData,
  output logic [7:0]     dataOut
);
  import dmaPkg::*;

  logic access;
  logic rdAccess;
  logic wrAccess;
  logic byteFf;

  // Exactly one strobe low makes a valid access
  assign access   = progMode && !csN && (iorN ^ iowN);
  assign rdAccess = access && !iorN;
  assign wrAccess = access && !iowN;

  assign opChan = addr[2:1];
  assign hiByte = byteFf;
  assign wrData = dataIn;

  // Strobes and address to one operation
  always_comb
  begin
    op = opNone;
    if (wrAccess)
    begin
      if (addr <= REG_CHAN_LAST)
        op = addr[0] ? opWrCount : opWrAddr;
      else
      begin
        case (addr)
          REG_COMMAND:      op = opWrCommand;
          REG_REQUEST:      op = opWrRequest;
          REG_SINGLE_MASK:  op = opWrSingleMask;
          REG_MODE:         op = opWrMode;
          REG_CLEAR_FF:     op = opClearFf;
          REG_MASTER_CLEAR: op = opMasterClear;
          REG_CLEAR_MASK:   op = opClearMask;
          default:          op = opWrAllMask;
        endcase
      end
    end
    else if (rdAccess)
    begin
      if (addr <= REG_CHAN_LAST)
        op = addr[0] ? opRdCount : opRdAddr;
      else if (addr == REG_STATUS)
        op = opRdStatus;
      else
        op = opRdZero;
    end
  end

  // Byte pointer flip-flop, low byte first
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      byteFf <= 1'b0;
    else if (op == opClearFf || op == opMasterClear)
      byteFf <= 1'b0;
    else if (op inside {opWrAddr, opWrCount, opRdAddr, opRdCount})
      byteFf <= !byteFf;
  end

  // Read data holds until the next read
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      dataOut <= 8'h00;
    else
    begin
      case (op)
        opRdAddr:   dataOut <= addrByte;
        opRdCount:  dataOut <= countByte;
        opRdStatus: dataOut <= status;
        opRdZero:   dataOut <= 8'h00;
        default:    dataOut <= dataOut;
      endcase
    end
  end

  // Host must never drive both strobes in a selected cycle
  assert property (@(posedge dma_if) disable iff (!rstN)
    !csN |-> (iorN || iowN));

endmodule

//--- design/dmaPkg.sv
// Shared DMA definitions: fixed at four channels with 16-bit address and count registers
package dmaPkg;

  // Channel count fixed by the register map
  localparam int NUM_CHANNELS = 4;

  typedef logic [1:0] chanIdx;

  // Register addresses as seen on the CPU port
  // 0..7 are channel registers: bit 0 selects count, bits 2:1 the channel
  localparam logic [3:0] REG_CHAN_LAST    = 4'd7;
  localparam logic [3:0] REG_COMMAND      = 4'd8;
  localparam logic [3:0] REG_STATUS       = 4'd8;
  localparam logic [3:0] REG_REQUEST      = 4'd9;
  localparam logic [3:0] REG_SINGLE_MASK  = 4'd10;
  localparam logic [3:0] REG_MODE         = 4'd11;
  localparam logic [3:0] REG_CLEAR_FF     = 4'd12;
  localparam logic [3:0] REG_MASTER_CLEAR = 4'd13;
  localparam logic [3:0] REG_TEMP         = 4'd13;
  localparam logic [3:0] REG_CLEAR_MASK   = 4'd14;
  localparam logic [3:0] REG_ALL_MASK     = 4'd15;

  // Command register bit that blocks all transfers
  localparam int CMD_DISABLE_BIT = 2;

  // One decoded CPU access
  typedef enum logic [3:0] {
    opNone,
    opWrAddr,
    opWrCount,
    opRdAddr,
    opRdCount,
    opWrCommand,
    opRdStatus,
    opWrRequest,
    opWrSingleMask,
    opWrMode,
    opClearFf,
    opMasterClear,
    opClearMask,
    opWrAllMask,
    opRdZero
  } regOp;

  // Mode register layout
  typedef struct packed {
    logic [1:0] serviceMode;
    logic       decrement;
    logic       autoInit;
    logic [1:0] transferType;
    chanIdx     chan;
  } modeWord;

  // Request and single mask layout
  typedef struct packed {
    logic [4:0] unused;
    logic       setBit;
    chanIdx     chan;
  } bitWord;

  // Programming byte, read as a mode word or as a channel bit word
  typedef union packed {
    modeWord mode;
    bitWord  bits;
  } ctlWord;

endpackage

//--- filelist.f
design/dmaPkg.sv
design/dmaHostPort.sv
design/dmaChannelRegs.sv
design/dmaControlRegs.sv
design/dmaDatapath.sv
sim/dmaClockGen.sv
sim/dmaDatapathTb.sv

//--- sim/dmaClockGen.sv
// Free-running 40 ns clock; reset low for the first two rising edges, released 1 ns after
`timescale 1ns/1ns

module dmaClockGen (
  output logic dma_if,
  output logic rstN
);

  initial
  begin
    dma_if = 1'b0;
    forever #20 dma_if = ~dma_if;
  end

  // Release just after the second edge
  initial
  begin
    rstN = 1'b0;
    repeat (2) @(posedge dma_if);
    #1 rstN = 1'b1;
  end

endmodule

//--- sim/dmaDatapathTb.sv
// Table-driven DMA datapath test; expected values come from a model run while the table is built
`timescale 1ns/1ns

module dmaDatapathTb;
  import dmaPkg::*;

  localparam int KIND_WR   = 0;
  localparam int KIND_RD   = 1;
  localparam int KIND_STEP = 2;
  localparam int KIND_DREQ = 3;
  localparam logic [31:0] SEED = 32'h4fcc5c7e;

  logic                    dma_if;
  logic                    rstN;
  logic                    csN;
  logic                    iorN;
  logic                    iowN;
  logic [3:0]              addr;
  logic [7:0]              dataIn;
  logic                    progMode;
  logic                    xferStep;
  logic [NUM_CHANNELS-1:0] dreq;
  logic [7:0]              dataOut;
  logic [15:0]             memAddr;
  logic                    tc;

  // Stimulus table: kind, register address, data, expected
  int          kindQ [$];
  logic [3:0]  addrQ [$];
  logic [7:0]  dataQ [$];
  logic [16:0] expQ [$];

  // Reference model state
  logic [15:0]             mBaseA [NUM_CHANNELS];
  logic [15:0]             mBaseC [NUM_CHANNELS];
  logic [15:0]             mCurA [NUM_CHANNELS];
  logic [15:0]             mCurC [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] mAuto;
  logic [NUM_CHANNELS-1:0] mDec;
  logic [NUM_CHANNELS-1:0] mMask;
  logic [NUM_CHANNELS-1:0] mTc;
  logic [NUM_CHANNELS-1:0] mDreq;
  logic                    mFf;
  logic                    mDis;
  chanIdx                  mReq;

  int cycles = 0;
  int cycleLimit = 0;
  int errCount = 0;

  dmaClockGen clockGen (
    .dma_if (dma_if),
    .rstN   (rstN)
  );

  dmaDatapath dut (
    .dma_if   (dma_if),
    .rstN     (rstN),
    .csN      (csN),
    .iorN     (iorN),
    .iowN     (iowN),
    .addr     (addr),
    .dataIn   (dataIn),
    .progMode (progMode),
    .xferStep (xferStep),
    .dreq     (dreq),
    .dataOut  (dataOut),
    .memAddr  (memAddr),
    .tc       (tc)
  );

  function automatic logic [7:0] randByte();
    randByte = 8'($urandom);
  endfunction

  task automatic checkValue(input logic [16:0] got, input logic [16:0] exp, input string what);
    if (got !== exp)
    begin
      errCount++;
      $display("** Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic clearModel();
    for (int i = 0; i < NUM_CHANNELS; i++)
    begin
      mBaseA[i] = '0;
      mBaseC[i] = '0;
      mCurA[i]  = '0;
      mCurC[i]  = '0;
    end
    mAuto = '0;
    mDec  = '0;
    mMask = '0;
    mTc   = '0;
    mFf   = 1'b0;
    mDis  = 1'b0;
    mReq  = '0;
  endtask

  task automatic addEntry(input int kind, input logic [3:0] a, input logic [7:0] d,
                          input logic [16:0] e);
    kindQ.push_back(kind);
    addrQ.push_back(a);
    dataQ.push_back(d);
    expQ.push_back(e);
  endtask

  task automatic addWrite(input logic [3:0] a, input logic [7:0] d);
    int lo;
    lo = mFf ? 8 : 0;
    if (a <= 4'd7)
    begin
      if (a[0])
      begin
        mBaseC[a[2:1]][lo +: 8] = d;
        mCurC[a[2:1]][lo +: 8]  = d;
      end
      else
      begin
        mBaseA[a[2:1]][lo +: 8] = d;
        mCurA[a[2:1]][lo +: 8]  = d;
      end
      mFf = !mFf;
    end
    else
    begin
      case (a)
        4'd8:  mDis = d[CMD_DISABLE_BIT];
        4'd9:  mReq = d[1:0];
        4'd10: mMask[d[1:0]] = d[2];
        4'd11:
        begin
          mDec[d[1:0]]  = d[5];
          mAuto[d[1:0]] = d[4];
        end
        4'd12: mFf = 1'b0;
        4'd13: clearModel();
        4'd14: mMask = '0;
        default: mMask = d[3:0];
      endcase
    end
    addEntry(KIND_WR, a, d, '0);
  endtask

  task automatic addRead(input logic [3:0] a);
    logic [7:0] e;
    int         lo;
    lo = mFf ? 8 : 0;
    e = 8'h00;
    if (a <= 4'd7)
    begin
      e = a[0] ? mCurC[a[2:1]][lo +: 8] : mCurA[a[2:1]][lo +: 8];
      mFf = !mFf;
    end
    else if (a == 4'd8)
    begin
      // TC flags clear once read
      e = {mDreq, mTc};
      mTc = '0;
    end
    addEntry(KIND_RD, a, 8'h00, {9'h000, e});
  endtask

  task automatic addStep();
    logic tcNow;
    tcNow = 1'b0;
    if (!mMask[mReq] && !mDis)
    begin
      tcNow = (mCurC[mReq] == 16'h0000);
      if (tcNow && mAuto[mReq])
      begin
        mCurA[mReq] = mBaseA[mReq];
        mCurC[mReq] = mBaseC[mReq];
      end
      else
      begin
        mCurA[mReq] = mDec[mReq] ? mCurA[mReq] - 16'd1 : mCurA[mReq] + 16'd1;
        mCurC[mReq] = mCurC[mReq] - 16'd1;
      end
      if (tcNow)
      begin
        mTc[mReq] = 1'b1;
        if (!mAuto[mReq])
          mMask[mReq] = 1'b1;
      end
    end
    addEntry(KIND_STEP, 4'd0, 8'h00, {tcNow, mCurA[mReq]});
  endtask

  task automatic addDreq(input logic [3:0] v);
    mDreq = v;
    addEntry(KIND_DREQ, 4'd0, {4'h0, v}, '0);
  endtask

  // Clear the byte pointer, then low and high bytes of address and count
  task automatic loadChannel(input chanIdx ch, input logic [15:0] a, input logic [15:0] c);
    addWrite(4'd12, randByte());
    addWrite({1'b0, ch, 1'b0}, a[7:0]);
    addWrite({1'b0, ch, 1'b0}, a[15:8]);
    addWrite({1'b0, ch, 1'b1}, c[7:0]);
    addWrite({1'b0, ch, 1'b1}, c[15:8]);
  endtask

  task automatic readChannel(input chanIdx ch);
    addWrite(4'd12, randByte());
    addRead({1'b0, ch, 1'b0});
    addRead({1'b0, ch, 1'b0});
    addRead({1'b0, ch, 1'b1});
    addRead({1'b0, ch, 1'b1});
  endtask

  // Unused mode fields get random bits
  task automatic setMode(input chanIdx ch, input logic dec, input logic ai);
    logic [7:0] r;
    r = randByte();
    addWrite(4'd11, {r[7:6], dec, ai, r[3:2], ch});
  endtask

  task automatic buildTable();
    // Everything reads zero after reset
    addRead(4'd8);
    readChannel(2'd0);
    for (int ch = 0; ch < NUM_CHANNELS; ch++)
    begin
      loadChannel(2'(ch), 16'($urandom), 16'($urandom));
      readChannel(2'(ch));
    end
    // Clear between bytes restarts at the low byte
    addWrite(4'd12, 8'h00);
    addWrite(4'd0, randByte());
    addWrite(4'd12, 8'h00);
    addWrite(4'd0, randByte());
    addWrite(4'd0, randByte());
    readChannel(2'd0);
    // Increment, then decrement
    loadChannel(2'd1, 16'($urandom), 16'd20);
    setMode(2'd1, 1'b0, 1'b0);
    addWrite(4'd9, 8'h05);
    repeat (3) addStep();
    readChannel(2'd1);
    setMode(2'd1, 1'b1, 1'b0);
    repeat (3) addStep();
    readChannel(2'd1);
    // Second step hits TC and reloads
    loadChannel(2'd2, 16'($urandom), 16'd1);
    setMode(2'd2, 1'b0, 1'b1);
    addWrite(4'd9, 8'h06);
    repeat (3) addStep();
    addRead(4'd8);
    // Temp register read follows a nonzero status byte
    addRead(4'd13);
    addRead(4'd8);
    readChannel(2'd2);
    // TC without autoinitialize masks channel 3
    loadChannel(2'd3, 16'($urandom), 16'd0);
    setMode(2'd3, 1'b1, 1'b0);
    addWrite(4'd9, 8'h07);
    repeat (2) addStep();
    addRead(4'd8);
    addWrite(4'd14, randByte());
    addStep();
    addWrite(4'd10, 8'h07);
    addStep();
    addWrite(4'd10, 8'h03);
    addStep();
    // Disable bit and all-mask both block steps
    addWrite(4'd8, 8'h04);
    addStep();
    addWrite(4'd8, 8'h00);
    addStep();
    addWrite(4'd15, 8'h0f);
    addStep();
    addWrite(4'd14, 8'h00);
    addStep();
    repeat (3)
    begin
      addDreq(4'($urandom));
      addRead(4'd8);
    end
    addWrite(4'd13, randByte());
    for (int a = 0; a < 8; a++)
    begin
      addRead(4'(a));
      addRead(4'(a));
    end
    addRead(4'd8);
  endtask

  // Run length limit
  always @(posedge dma_if)
  begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycleLimit);
      $display("tests failed");
      $fatal(1, "Simulation timed out");
    end
  end

  initial
  begin
    void'($urandom(SEED));
    csN      = 1'b1;
    iorN     = 1'b1;
    iowN     = 1'b1;
    addr     = 4'd0;
    dataIn   = 8'h00;
    progMode = 1'b0;
    xferStep = 1'b0;
    dreq     = '0;
    clearModel();
    mDreq = '0;
    buildTable();
    cycleLimit = 2 * (kindQ.size() * 2) + 2;
    wait (rstN === 1'b1);
    progMode = 1'b1;
    for (int i = 0; i < kindQ.size(); i++)
    begin
      @(posedge dma_if);
      #1;
      // No step on the idle edge leaves tc low
      checkValue({16'h0000, tc}, 17'h00000, $sformatf("tc before entry %0d", i));
      case (kindQ[i])
        KIND_WR:
        begin
          csN    = 1'b0;
          iowN   = 1'b0;
          addr   = addrQ[i];
          dataIn = dataQ[i];
        end
        KIND_RD:
        begin
          csN  = 1'b0;
          iorN = 1'b0;
          addr = addrQ[i];
        end
        KIND_STEP: xferStep = 1'b1;
        default: dreq = dataQ[i][3:0];
      endcase
      // Access edge, then idle cycle
      @(posedge dma_if);
      #1;
      csN      = 1'b1;
      iorN     = 1'b1;
      iowN     = 1'b1;
      xferStep = 1'b0;
      if (kindQ[i] == KIND_RD)
        checkValue({9'h000, dataOut}, expQ[i], $sformatf("entry %0d read", i));
      else if (kindQ[i] == KIND_STEP)
        checkValue({tc, memAddr}, expQ[i], $sformatf("entry %0d step", i));
    end
    if (errCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
